// ==== src/booth_config.svh ====
// build-time sizing only; STEPS must equal WIDTH and STEPS_PER_STAGE must divide STEPS
`ifndef BOOTH_CONFIG_SVH
`define BOOTH_CONFIG_SVH

`define BOOTH_WIDTH 8            // operand width, 8 is the only supported value
`define BOOTH_STEPS 8            // one radix-2 step per multiplier bit
`define BOOTH_STEPS_PER_STAGE 2  // legal values 1, 2, 4, 8

`define MAC_ACC_WIDTH 24         // running sum wraps in two's complement

`endif

// ==== src/booth_pkg.sv ====
// shared datapath types; field widths follow booth_config.svh and assume signed 8-bit operands
`default_nettype none

`include "booth_config.svh"

package booth_pkg;

	// partial product state handed from one Booth step to the next
	typedef struct packed {
		logic [`BOOTH_WIDTH-1:0] acc;          // upper half
		logic [`BOOTH_WIDTH-1:0] q;            // lower half, starts as the sample
		logic                    q_m1;         // last bit shifted out of q
		logic [`BOOTH_WIDTH-1:0] multiplicand; // coefficient captured at entry
	} booth_state_t;

	// register block settings that steer the datapath
	typedef struct packed {
		logic signed [`BOOTH_WIDTH-1:0] coeff;
		logic                           acc_en;
	} mac_cfg_t;

	// pipeline result, valid is a one-cycle pulse
	typedef struct packed {
		logic                             valid;
		logic signed [2*`BOOTH_WIDTH-1:0] value;
	} product_t;

endpackage

`default_nettype wire

// ==== src/booth_addsub.sv ====
// combinational 8-bit add or subtract, carry out is dropped so results wrap
`timescale 1ns/1ps
`default_nettype none

`include "booth_config.svh"

module booth_addsub (
	input  logic                    sub,
	input  logic [`BOOTH_WIDTH-1:0] a,
	input  logic [`BOOTH_WIDTH-1:0] b,
	output logic [`BOOTH_WIDTH-1:0] result
);

	localparam int W = `BOOTH_WIDTH;

	logic [W-1:0] b_eff; // b or its ones complement

	// sub doubles as the inverter control and the carry-in
	assign b_eff = b ^ {W{sub}};

	always_comb begin
		logic carry;
		carry = sub; // +1 completes the twos complement on subtract
		for (int i = 0; i < W; i++) begin
			result[i] = a[i] ^ b_eff[i] ^ carry;
			carry     = (a[i] & b_eff[i]) | (b_eff[i] & carry) | (carry & a[i]);
		end
	end

endmodule

`default_nettype wire

// ==== src/booth_step.sv ====
// one combinational radix-2 Booth step; expects a signed multiplicand and an acc/q pair
`timescale 1ns/1ps
`default_nettype none

`include "booth_config.svh"

module booth_step (
	input  booth_pkg::booth_state_t state_in,
	output booth_pkg::booth_state_t state_out
);

	localparam int W = `BOOTH_WIDTH;

	logic [W-1:0] addsub_res;
	logic [W-1:0] acc_sel;  // acc before the shift
	logic         acc_sign; // sign of acc_sel taken one bit wider
	logic         b_top;    // multiplicand sign as the adder sees it

	// pair 10 subtracts, 01 adds, so q[0] alone picks the operation
	booth_addsub u_addsub (
		.sub   (state_in.q[0]),
		.a     (state_in.acc),
		.b     (state_in.multiplicand),
		.result(addsub_res)
	);

	always_comb begin
		b_top = state_in.multiplicand[W-1] ^ state_in.q[0];

		if (state_in.q[0] != state_in.q_m1) begin
			acc_sel = addsub_res;
			// operands of equal sign keep it even when the byte overflows
			if (state_in.acc[W-1] == b_top)
				acc_sign = state_in.acc[W-1];
			else
				acc_sign = addsub_res[W-1];
		end else begin
			acc_sel  = state_in.acc; // 00 or 11, nothing to add
			acc_sign = state_in.acc[W-1];
		end

		// arithmetic shift of the acc/q pair
		state_out.acc          = {acc_sign, acc_sel[W-1:1]};
		state_out.q            = {acc_sel[0], state_in.q[W-1:1]};
		state_out.q_m1         = state_in.q[0];
		state_out.multiplicand = state_in.multiplicand; // rides along unchanged
	end

endmodule

`default_nettype wire

// ==== src/booth_pipeline.sv ====
// fixed latency of STEPS/STEPS_PER_STAGE edges, accepts one sample per cycle, no stall
`timescale 1ns/1ps
`default_nettype none

`include "booth_config.svh"

module booth_pipeline (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           in_valid,
	input  logic signed [`BOOTH_WIDTH-1:0] in_sample,
	input  logic signed [`BOOTH_WIDTH-1:0] in_coeff,
	output booth_pkg::product_t            out
);

	import booth_pkg::*;

	localparam int SPS    = `BOOTH_STEPS_PER_STAGE;
	localparam int STAGES = `BOOTH_STEPS / `BOOTH_STEPS_PER_STAGE;

	booth_state_t      init_state;
	booth_state_t      step_in     [`BOOTH_STEPS];
	booth_state_t      step_out    [`BOOTH_STEPS];
	booth_state_t      stage_state [STAGES];
	logic [STAGES-1:0] stage_valid;

	// coefficient is captured here and travels with its sample
	always_comb begin
		init_state.acc          = '0;
		init_state.q            = in_sample;
		init_state.q_m1         = 1'b0;
		init_state.multiplicand = in_coeff;
	end

	for (genvar i = 0; i < `BOOTH_STEPS; i++) begin : g_step
		if (i == 0) begin : g_first
			assign step_in[i] = init_state;
		end else if (i % SPS == 0) begin : g_from_reg
			assign step_in[i] = stage_state[i/SPS - 1]; // start of a new stage
		end else begin : g_from_step
			assign step_in[i] = step_out[i-1];
		end

		booth_step u_step (
			.state_in (step_in[i]),
			.state_out(step_out[i])
		);
	end

	// stage registers sit after every SPS steps
	for (genvar k = 0; k < STAGES; k++) begin : g_stage
		always_ff @(posedge clk) begin
			stage_state[k] <= step_out[(k+1)*SPS - 1];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stage_valid <= '0;
		end else begin
			stage_valid[0] <= in_valid;
			for (int k = 1; k < STAGES; k++)
				stage_valid[k] <= stage_valid[k-1];
		end
	end

	// acc holds the upper byte, q the lower byte
	always_comb begin
		out.valid = stage_valid[STAGES-1];
		out.value = {stage_state[STAGES-1].acc, stage_state[STAGES-1].q};
	end

endmodule

`default_nettype wire

// ==== src/mac_regs.sv ====
// addr 0 coeff, addr 1 ctrl bit 0 acc_en, addr 2 write-only clear; readback is combinational
`timescale 1ns/1ps
`default_nettype none

`include "booth_config.svh"

module mac_regs (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    cfg_we,
	input  logic [1:0]              cfg_addr,
	input  logic [`BOOTH_WIDTH-1:0] cfg_wdata,
	output logic [`BOOTH_WIDTH-1:0] cfg_rdata,
	output booth_pkg::mac_cfg_t     cfg,
	output logic                    clear
);

	localparam logic [1:0] ADDR_COEFF = 2'd0;
	localparam logic [1:0] ADDR_CTRL  = 2'd1;
	localparam logic [1:0] ADDR_CLEAR = 2'd2;

	logic wr_coeff;
	logic wr_ctrl;

	assign wr_coeff = cfg_we && (cfg_addr == ADDR_COEFF);
	assign wr_ctrl  = cfg_we && (cfg_addr == ADDR_CTRL);

	// strobe lasts for the write cycle, acted on at the next edge
	assign clear = cfg_we && (cfg_addr == ADDR_CLEAR);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg.coeff  <= '0;
			cfg.acc_en <= 1'b0;
		end else begin
			if (wr_coeff)
				cfg.coeff <= cfg_wdata;
			if (wr_ctrl)
				cfg.acc_en <= cfg_wdata[0]; // upper ctrl bits not stored
		end
	end

	always_comb begin
		case (cfg_addr)
			ADDR_COEFF: cfg_rdata = cfg.coeff;
			ADDR_CTRL:  cfg_rdata = {{(`BOOTH_WIDTH-1){1'b0}}, cfg.acc_en};
			default:    cfg_rdata = '0; // clear and spare addr read zero
		endcase
	end

endmodule

`default_nettype wire

// ==== src/mac_accumulator.sv ====
// 24-bit wrapping sum, no saturation; clear with an enabled product loads that product
`timescale 1ns/1ps
`default_nettype none

`include "booth_config.svh"

module mac_accumulator (
	input  logic                             clk,
	input  logic                             rst_n,
	input  booth_pkg::product_t              prod,
	input  logic                             acc_en,
	input  logic                             clear,
	output logic signed [`MAC_ACC_WIDTH-1:0] sum,
	output logic                             sum_valid
);

	localparam int PW = 2 * `BOOTH_WIDTH;
	localparam int AW = `MAC_ACC_WIDTH;

	logic                 add_now;
	logic signed [AW-1:0] prod_ext;

	assign add_now  = prod.valid && acc_en;
	assign prod_ext = {{(AW-PW){prod.value[PW-1]}}, prod.value}; // sign extend

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sum       <= '0;
			sum_valid <= 1'b0;
		end else begin
			sum_valid <= add_now;

			// clear wins over the old sum but keeps a product arriving with it
			if (clear)
				sum <= add_now ? prod_ext : '0;
			else if (add_now)
				sum <= sum + prod_ext;
		end
	end

endmodule

`default_nettype wire

// ==== src/booth_mac_top.sv ====
// outputs are single-cycle pulses with no back-pressure; product latency set in the config header
`timescale 1ns/1ps
`default_nettype none

`include "booth_config.svh"

module booth_mac_top (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               cfg_we,
	input  logic [1:0]                         cfg_addr,
	input  logic [`BOOTH_WIDTH-1:0]            cfg_wdata,
	output logic [`BOOTH_WIDTH-1:0]            cfg_rdata,
	input  logic                               sample_valid,
	input  logic signed [`BOOTH_WIDTH-1:0]     sample_data,
	output logic                               product_valid,
	output logic signed [2*`BOOTH_WIDTH-1:0]   product,
	output logic                               sum_valid,
	output logic signed [`MAC_ACC_WIDTH-1:0]   sum
);

	import booth_pkg::*;

	mac_cfg_t cfg;
	logic     clear;
	product_t prod;

	mac_regs u_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.cfg_we   (cfg_we),
		.cfg_addr (cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.cfg      (cfg),
		.clear    (clear)
	);

	booth_pipeline u_pipe (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (sample_valid),
		.in_sample(sample_data),
		.in_coeff (cfg.coeff),
		.out      (prod)
	);

	mac_accumulator u_acc (
		.clk      (clk),
		.rst_n    (rst_n),
		.prod     (prod),
		.acc_en   (cfg.acc_en),
		.clear    (clear),
		.sum      (sum),
		.sum_valid(sum_valid)
	);

	assign product_valid = prod.valid;
	assign product       = prod.value;

endmodule

`default_nettype wire

// ==== testbench/booth_mac_tests.svh ====
// directed tests for booth_mac_tb; products and sums are also checked by its monitor
`ifndef BOOTH_MAC_TESTS_SVH
`define BOOTH_MAC_TESTS_SVH

task automatic drive_idle();
	drive_cycle(1'b0, 8'h00, 1'b0, 2'd0, 8'h00);
endtask

task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
	drive_cycle(1'b0, 8'h00, 1'b1, addr, data);
endtask

task automatic read_reg(input logic [1:0] addr, output logic [7:0] data);
	drive_cycle(1'b0, 8'h00, 1'b0, addr, 8'h00);
	@(negedge clk);
	data = cfg_rdata; // combinational readback, settled for a whole cycle
endtask

task automatic issue_sample(input logic [7:0] data);
	drive_cycle(1'b1, data, 1'b0, 2'd0, 8'h00);
endtask

// returns on the falling edge where product_valid is high
task automatic wait_product();
	do
		drive_idle();
	while (!product_valid);
endtask

task automatic wait_drain();
	do
		drive_idle();
	while (sb_queue.size() != 0);
endtask

task automatic register_access();
	logic [7:0] rd;
	current_test = "register_access";
	read_reg(2'd0, rd);
	check_equal("coeff after reset", 0, 32'(rd));
	read_reg(2'd1, rd);
	check_equal("ctrl after reset", 0, 32'(rd));
	write_reg(2'd0, 8'hA5);
	write_reg(2'd1, 8'hFF); // only bit 0 is kept
	read_reg(2'd0, rd);
	check_equal("coeff readback", 32'h0A5, 32'(rd));
	read_reg(2'd1, rd);
	check_equal("ctrl readback", 1, 32'(rd));
	write_reg(2'd2, 8'h5A);
	read_reg(2'd2, rd);
	check_equal("clear readback", 0, 32'(rd));
	write_reg(2'd1, 8'h00);
endtask

task automatic corner_products();
	logic signed [7:0] smp [6];
	logic signed [7:0] cof [6];
	current_test = "corner_products";
	smp = '{8'h80, 8'h80, 8'h7F, 8'h00, 8'hFF, 8'h7F};
	cof = '{8'h80, 8'h7F, 8'h7F, 8'h00, 8'hFF, 8'h80};
	cof[3] = rand_byte(); // zero times anything
	for (int i = 0; i < 6; i++) begin
		write_reg(2'd0, cof[i]);
		issue_sample(smp[i]);
		wait_product();
		check_equal("corner product", int'(smp[i]) * int'(cof[i]), 32'(product));
		wait_drain();
	end
endtask

task automatic random_stream();
	logic [7:0] smp;
	logic [7:0] cof;
	current_test = "random_stream";
	for (int i = 0; i < 200; i++) begin
		smp = rand_byte();
		if (i % 25 == 0) begin
			cof = rand_byte();
			drive_cycle(1'b1, smp, 1'b1, 2'd0, cof);
		end else begin
			issue_sample(smp);
		end
	end
	wait_drain();
endtask

// new coefficient written in the same cycle as each strobe
task automatic coeff_change_in_flight();
	logic [7:0] smp;
	logic [7:0] cof;
	current_test = "coeff_change_in_flight";
	for (int i = 0; i < 8; i++) begin
		smp = rand_byte();
		cof = rand_byte();
		drive_cycle(1'b1, smp, 1'b1, 2'd0, cof);
	end
	wait_drain();
endtask

task automatic accumulation();
	logic signed [7:0]  smp;
	logic signed [23:0] held;
	current_test = "accumulation";
	write_reg(2'd2, 8'h00);
	write_reg(2'd1, 8'h01);
	write_reg(2'd0, rand_byte());
	for (int i = 0; i < 60; i++)
		issue_sample(rand_byte());
	wait_drain();
	check_equal("running sum", 32'(sum_model), 32'(sum));

	// 520 products of 16384 pass the top of the 24-bit range
	write_reg(2'd0, 8'h80);
	for (int i = 0; i < 520; i++)
		issue_sample(8'h80);
	wait_drain();
	check_equal("wrapped sum", 32'(sum_model), 32'(sum));

	smp = rand_byte();
	issue_sample(smp);
	wait_product();
	set_inputs(1'b0, 8'h00, 1'b1, 2'd2, 8'h00); // clear meets the product
	drive_idle();
	check_equal("sum after clear", int'(smp) * -128, 32'(sum));

	write_reg(2'd1, 8'h00);
	held = sum;
	for (int i = 0; i < 10; i++)
		issue_sample(rand_byte());
	wait_drain();
	check_equal("sum held", 32'(held), 32'(sum));
endtask

`endif

// ==== testbench/booth_mac_tb.sv ====
// self-checking testbench for booth_mac_top; assumes 8-bit operands, stops at the first error
`timescale 1ns/1ps
`default_nettype none

`include "booth_config.svh"

module booth_mac_tb;

	localparam int RESET_CYCLES = 16;
	localparam int LATENCY      = `BOOTH_STEPS / `BOOTH_STEPS_PER_STAGE;
	localparam int N_SAMPLES    = 805; // strobes over all tests
	localparam int N_REG_CYCLES = 30;  // register writes and reads
	localparam int N_WAITS      = 20;  // waits for a product or an empty pipeline
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_SAMPLES + N_REG_CYCLES
		+ N_WAITS * (LATENCY + 2) + 100;

	// one record per strobed sample
	typedef struct packed {
		logic signed [`BOOTH_WIDTH-1:0] sample;
		logic signed [`BOOTH_WIDTH-1:0] coeff;
		logic [31:0]                    cycle;
	} sb_entry_t;

	logic                               clk;
	logic                               rst_n;
	logic                               cfg_we;
	logic [1:0]                         cfg_addr;
	logic [`BOOTH_WIDTH-1:0]            cfg_wdata;
	logic [`BOOTH_WIDTH-1:0]            cfg_rdata;
	logic                               sample_valid;
	logic signed [`BOOTH_WIDTH-1:0]     sample_data;
	logic                               product_valid;
	logic signed [2*`BOOTH_WIDTH-1:0]   product;
	logic                               sum_valid;
	logic signed [`MAC_ACC_WIDTH-1:0]   sum;

	sb_entry_t                          sb_queue[$];
	logic signed [`BOOTH_WIDTH-1:0]     coeff_model;
	logic                               acc_en_model;
	logic signed [`MAC_ACC_WIDTH-1:0]   sum_model;
	logic                               sum_valid_model;
	logic [31:0]                        lfsr_state;
	int                                 cycle_count = 0;
	int                                 error_count = 0;
	string                              current_test = "reset";

	booth_mac_top booth_mac_top_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.cfg_we       (cfg_we),
		.cfg_addr     (cfg_addr),
		.cfg_wdata    (cfg_wdata),
		.cfg_rdata    (cfg_rdata),
		.sample_valid (sample_valid),
		.sample_data  (sample_data),
		.product_valid(product_valid),
		.product      (product),
		.sum_valid    (sum_valid),
		.sum          (sum)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// right-shift Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			b[i]       = lfsr_state[0]; // one step per bit
			lfsr_state = lfsr_step(lfsr_state);
		end
		return b;
	endfunction

	task automatic report_failure(input string msg);
		error_count++;
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_equal(input string what, input logic signed [31:0] expected,
		input logic signed [31:0] actual);
		if (expected !== actual)
			report_failure($sformatf("Mismatch in %s: %s expected %0d, actual %0d",
				current_test, what, expected, actual));
	endtask

	task automatic set_inputs(input logic sv, input logic [7:0] sdata, input logic we,
		input logic [1:0] addr, input logic [7:0] wdata);
		sample_valid = sv;
		sample_data  = sdata;
		cfg_we       = we;
		cfg_addr     = addr;
		cfg_wdata    = wdata;
	endtask

	task automatic drive_cycle(input logic sv, input logic [7:0] sdata, input logic we,
		input logic [1:0] addr, input logic [7:0] wdata);
		@(negedge clk);
		set_inputs(sv, sdata, we, addr, wdata);
	endtask

	// scoreboard and running-sum model, sampled at the rising edge
	always @(posedge clk) begin : monitor
		sb_entry_t ent;
		int        exp_prod;
		logic      add_now;
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
			report_failure($sformatf("Timeout: run not finished after %0d cycles",
				TIMEOUT_CYCLES));
		if (!rst_n) begin
			coeff_model     = '0;
			acc_en_model    = 1'b0;
			sum_model       = '0;
			sum_valid_model = 1'b0;
			sb_queue.delete();
		end else begin
			// these outputs were set by the previous edge
			check_equal("sum_valid", 32'(sum_valid_model), 32'(sum_valid));
			check_equal("sum", 32'(sum_model), 32'(sum));
			add_now  = 1'b0;
			exp_prod = 0;
			if (product_valid) begin
				if (sb_queue.size() == 0)
					report_failure("product_valid pulsed with no sample in the pipeline");
				ent      = sb_queue.pop_front();
				exp_prod = int'(ent.sample) * int'(ent.coeff);
				check_equal("product", exp_prod, 32'(product));
				check_equal("latency", LATENCY, cycle_count - int'(ent.cycle));
				add_now = acc_en_model;
			end
			sum_valid_model = add_now;
			if (cfg_we && cfg_addr == 2'd2)
				sum_model = add_now ? 24'(exp_prod) : '0;
			else if (add_now)
				sum_model = 24'(sum_model + exp_prod); // wraps at 24 bits
			if (sample_valid) begin
				ent.sample = sample_data;
				ent.coeff  = coeff_model; // value before any write on this edge
				ent.cycle  = cycle_count;
				sb_queue.push_back(ent);
			end
			if (cfg_we && cfg_addr == 2'd0)
				coeff_model = cfg_wdata;
			if (cfg_we && cfg_addr == 2'd1)
				acc_en_model = cfg_wdata[0];
		end
	end

	`include "booth_mac_tests.svh"

	initial begin
		rst_n      = 1'b0;
		lfsr_state = 32'd88349;
		set_inputs(1'b0, 8'h00, 1'b0, 2'd0, 8'h00);
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		register_access();
		corner_products();
		random_stream();
		coeff_change_in_flight();
		accumulation();
		drive_idle();

		if (error_count == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("Finished with errors");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+src
+incdir+testbench
src/booth_pkg.sv
src/booth_addsub.sv
src/booth_step.sv
src/booth_pipeline.sv
src/mac_regs.sv
src/mac_accumulator.sv
src/booth_mac_top.sv
testbench/booth_mac_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       := booth_mac_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
